/* blast_pkg.sv */
`default_nettype none

package blast_pkg;

   localparam int word_bits   = 64;
   localparam int addr_bits   = 14;
   localparam int char_bits   = 3;
   localparam int field_bits  = 8;
   localparam int query_words = 6;
   localparam int query_chars = 128;
   localparam int block_words = 3;
   localparam int block_chars = 64;
   localparam int seed_len    = 4;
   localparam int fifo_depth  = 64;

   // memory map
   localparam logic [addr_bits-1:0] query_base   = 14'd0;
   localparam logic [addr_bits-1:0] subject_base = 14'd12;
   localparam logic [addr_bits-1:0] hit_base     = 14'd4096;

   localparam logic [7:0] cmd_load_query   = 8'hAA;
   localparam logic [7:0] cmd_scan_subject = 8'hBB;

   // sequencer states
   localparam logic [2:0] st_idle   = 3'd0;
   localparam logic [2:0] st_load   = 3'd1;
   localparam logic [2:0] st_header = 3'd2;
   localparam logic [2:0] st_block  = 3'd3;
   localparam logic [2:0] st_stream = 3'd4;
   localparam logic [2:0] st_hits   = 3'd5;
   localparam logic [2:0] st_hdr    = 3'd6;

   typedef struct packed {
      logic [field_bits-1:0] q_pos;
      logic [field_bits-1:0] s_pos;
      logic [field_bits-1:0] block;
      logic [field_bits-1:0] count;
   } hit_rec_t;

   // one memory word, read as subject header or written as hit record
   typedef union packed {
      logic [word_bits-1:0] raw;
      struct packed {
         logic [31:0] subject_id;
         logic [31:0] length;
      } header;
      struct packed {
         hit_rec_t    rec;
         logic [31:0] pad;
      } hit;
   } mem_word_u;

endpackage

`default_nettype wire

/* seed_scanner.sv */
`default_nettype none

module seed_scanner import blast_pkg::*; (
   input  wire                   clk,
   input  wire                   reset,
   input  wire  [char_bits-1:0]  q_char,
   input  wire                   q_valid,
   input  wire  [char_bits-1:0]  s_char,
   input  wire                   s_valid,
   input  wire  [field_bits-1:0] block,
   output logic                  push,
   output hit_rec_t              hit,
   output logic                  idle
);

   logic [char_bits-1:0]          q_mem [query_chars];
   logic [$clog2(query_chars)-1:0] q_idx;
   logic [seed_len*char_bits-1:0] win;
   logic [6:0]                    s_cnt;
   logic                          s_prev;
   logic                          cmp_valid;
   logic [field_bits-1:0]         cmp_pos;
   logic [field_bits-1:0]         match_cnt;
   logic [field_bits-1:0]         match_pos;

   assign idle = !s_valid && !cmp_valid && !push;

   // index wraps after 128, so a reload starts at 0 again
   always_ff @(posedge clk) begin
      if (q_valid) begin
         q_mem[q_idx] <= q_char;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         q_idx <= '0;
      end else if (q_valid) begin
         q_idx <= q_idx + 1'b1;
      end
   end

   // oldest character sits in the top bits of the window
   always_comb begin
      logic [seed_len*char_bits-1:0] q_win;
      match_cnt = '0;
      match_pos = '0;
      q_win     = '0;
      for (int q = 0; q <= query_chars - seed_len; q++) begin
         for (int k = 0; k < seed_len; k++) begin
            q_win[(seed_len-1-k)*char_bits +: char_bits] = q_mem[q+k];
         end
         if (q_win == win) begin
            if (match_cnt == '0) begin
               match_pos = field_bits'(q);
            end
            match_cnt = match_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         s_prev    <= 1'b0;
         s_cnt     <= '0;
         cmp_valid <= 1'b0;
         push      <= 1'b0;
      end else begin
         s_prev    <= s_valid;
         cmp_valid <= 1'b0;
         push      <= cmp_valid && match_cnt != '0;
         if (s_valid && !s_prev) begin
            s_cnt <= 7'd1;
         end else if (s_valid) begin
            s_cnt     <= s_cnt + 1'b1;
            cmp_valid <= s_cnt >= 7'(seed_len - 1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (s_valid && !s_prev) begin
         win <= {{(seed_len-1)*char_bits{1'b0}}, s_char};
      end else if (s_valid) begin
         win     <= {win[(seed_len-1)*char_bits-1:0], s_char};
         cmp_pos <= field_bits'(s_cnt) - field_bits'(seed_len - 1);
      end
      if (cmp_valid) begin
         hit.q_pos <= match_pos;
         hit.s_pos <= cmp_pos;
         hit.block <= block;
         hit.count <= match_cnt;
      end
   end

endmodule

`default_nettype wire

/* hit_fifo.sv */
`default_nettype none

module hit_fifo import blast_pkg::*; (
   input  wire           clk,
   input  wire           reset,
   input  wire           push,
   input  wire hit_rec_t din,
   input  wire           pop,
   output hit_rec_t      dout,
   output logic          empty
);

   hit_rec_t                      mem [fifo_depth];
   logic [$clog2(fifo_depth)-1:0] wr_ptr;
   logic [$clog2(fifo_depth)-1:0] rd_ptr;

   // head entry always sits on dout
   assign dout  = mem[rd_ptr];
   assign empty = wr_ptr == rd_ptr;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop && !empty) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* char_serializer.sv */
`default_nettype none

module char_serializer import blast_pkg::*; #(
   parameter int num_words = 3
) (
   input  wire                  clk,
   input  wire                  reset,
   input  wire  [word_bits-1:0] word,
   input  wire                  word_valid,
   input  wire                  start,
   output logic [char_bits-1:0] char_out,
   output logic                 char_valid,
   output logic                 busy
);

   logic [num_words*word_bits-1:0] shreg;
   logic [7:0]                     remaining;

   assign busy = char_valid;

   // new words enter at the top, so word 0 ends up lowest
   always_ff @(posedge clk) begin
      if (word_valid) begin
         shreg <= {word, shreg[num_words*word_bits-1:word_bits]};
      end else if (start || remaining != '0) begin
         char_out <= shreg[char_bits-1:0];
         shreg    <= shreg >> char_bits;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         remaining  <= '0;
         char_valid <= 1'b0;
      end else if (start) begin
         remaining  <= 8'(num_words * word_bits / char_bits - 1);
         char_valid <= 1'b1;
      end else if (remaining != '0) begin
         remaining  <= remaining - 1'b1;
         char_valid <= 1'b1;
      end else begin
         char_valid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* blast_sequencer.sv */
`default_nettype none

module blast_sequencer import blast_pkg::*; (
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   app_ready,
   input  wire  [7:0]            app_code,
   input  wire  [word_bits-1:0]  dat_r,
   input  wire                   ack,
   input  wire                   q_busy,
   input  wire                   s_busy,
   input  wire                   scan_idle,
   input  wire                   fifo_empty,
   input  wire hit_rec_t         fifo_data,
   output logic                  busy,
   output logic                  cyc,
   output logic                  stb,
   output logic                  we,
   output logic [addr_bits-1:0]  adr,
   output logic [word_bits-1:0]  dat_w,
   output logic                  q_word_valid,
   output logic                  q_start,
   output logic                  s_word_valid,
   output logic                  s_start,
   output logic [word_bits-1:0]  s_word,
   output logic [field_bits-1:0] block,
   output logic                  fifo_pop
);

   logic [2:0]           state;
   logic                 req;
   logic                 xfer;
   logic [2:0]           word_cnt;
   logic [addr_bits-1:0] rd_adr;
   logic [addr_bits-1:0] hit_adr;
   logic [31:0]          hit_bytes;
   logic [31:0]          char_cnt;
   logic                 launched;
   logic [31:0]          subject_id;
   logic [31:0]          length;
   logic                 issue_rd;
   logic                 issue_hit;
   logic                 issue_hdr;
   mem_word_u            rd_word;
   mem_word_u            hit_word;
   mem_word_u            hdr_word;

   assign cyc  = req;
   assign stb  = req;
   assign xfer = req & ack;

   // a new request only starts after stb has been low for a cycle
   assign issue_rd  = !req && ((state == st_load && !q_busy && !q_start) ||
                               state == st_header || state == st_block);
   assign issue_hit = !req && state == st_hits && !fifo_empty;
   assign issue_hdr = !req && state == st_hdr;
   assign fifo_pop  = issue_hit;

   assign q_word_valid = xfer && state == st_load;

   // wait for the query stream and the last block word before starting
   assign s_start = state == st_stream && !launched && !q_busy && !q_start &&
                    !s_word_valid;

   assign rd_word = dat_r;

   always_comb begin
      hit_word.hit.rec = fifo_data;
      hit_word.hit.pad = '0;
   end

   always_comb begin
      hdr_word.header.subject_id = subject_id;
      hdr_word.header.length     = hit_bytes;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= st_idle;
         req          <= 1'b0;
         we           <= 1'b0;
         busy         <= 1'b0;
         word_cnt     <= '0;
         rd_adr       <= '0;
         hit_adr      <= '0;
         hit_bytes    <= '0;
         char_cnt     <= '0;
         block        <= '0;
         launched     <= 1'b0;
         s_word_valid <= 1'b0;
         q_start      <= 1'b0;
      end else begin
         s_word_valid <= 1'b0;
         q_start      <= 1'b0;
         if (xfer) begin
            req <= 1'b0;
         end else if (issue_rd || issue_hit || issue_hdr) begin
            req <= 1'b1;
            we  <= !issue_rd;
         end
         case (state)
            st_idle: begin
               if (app_ready && app_code == cmd_load_query) begin
                  state    <= st_load;
                  busy     <= 1'b1;
                  rd_adr   <= query_base;
                  word_cnt <= '0;
               end else if (app_ready && app_code == cmd_scan_subject) begin
                  state     <= st_header;
                  busy      <= 1'b1;
                  rd_adr    <= subject_base;
                  hit_adr   <= hit_base + 1'b1;
                  hit_bytes <= '0;
                  char_cnt  <= '0;
                  block     <= '0;
               end
            end
            st_load: begin
               if (xfer) begin
                  rd_adr   <= rd_adr + 1'b1;
                  word_cnt <= word_cnt + 1'b1;
                  if (word_cnt == 3'(query_words - 1)) begin
                     q_start <= 1'b1;
                     busy    <= 1'b0;
                     state   <= st_idle;
                  end
               end
            end
            st_header: begin
               if (xfer) begin
                  rd_adr   <= rd_adr + 1'b1;
                  word_cnt <= '0;
                  state    <= st_block;
               end
            end
            st_block: begin
               if (xfer) begin
                  rd_adr       <= rd_adr + 1'b1;
                  s_word_valid <= 1'b1;
                  word_cnt     <= word_cnt + 1'b1;
                  if (word_cnt == 3'(block_words - 1)) begin
                     char_cnt <= char_cnt + 32'(block_chars);
                     launched <= 1'b0;
                     state    <= st_stream;
                  end
               end
            end
            st_stream: begin
               if (s_start) begin
                  launched <= 1'b1;
               end else if (launched && !s_busy && scan_idle) begin
                  state <= st_hits;
               end
            end
            st_hits: begin
               if (issue_hit) begin
                  hit_adr   <= hit_adr + 1'b1;
                  hit_bytes <= hit_bytes + 32'(word_bits / 8);
               end else if (!req && fifo_empty) begin
                  if (char_cnt >= length) begin
                     state <= st_hdr;
                  end else begin
                     block    <= block + 1'b1;
                     word_cnt <= '0;
                     state    <= st_block;
                  end
               end
            end
            st_hdr: begin
               if (xfer) begin
                  busy  <= 1'b0;
                  state <= st_idle;
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   // bus payload and subject header fields
   always_ff @(posedge clk) begin
      if (issue_rd) begin
         adr <= rd_adr;
      end else if (issue_hit) begin
         adr   <= hit_adr;
         dat_w <= hit_word.raw;
      end else if (issue_hdr) begin
         adr   <= hit_base;
         dat_w <= hdr_word.raw;
      end
      if (xfer && state == st_header) begin
         subject_id <= rd_word.header.subject_id;
         length     <= rd_word.header.length;
      end
      if (xfer && state == st_block) begin
         s_word <= dat_r;
      end
   end

endmodule

`default_nettype wire

/* blast_top.sv */
`default_nettype none

module blast_top import blast_pkg::*; (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  app_ready,
   input  wire [7:0]            app_code,
   output logic                 busy,
   output logic                 cyc,
   output logic                 stb,
   output logic                 we,
   output logic [addr_bits-1:0] adr,
   output logic [word_bits-1:0] dat_w,
   input  wire  [word_bits-1:0] dat_r,
   input  wire                  ack
);

   wire                  q_word_valid;
   wire                  q_start;
   wire                  q_busy;
   wire [char_bits-1:0]  q_char;
   wire                  q_valid;
   wire                  s_word_valid;
   wire                  s_start;
   wire                  s_busy;
   wire [word_bits-1:0]  s_word;
   wire [char_bits-1:0]  s_char;
   wire                  s_valid;
   wire [field_bits-1:0] block;
   wire                  scan_idle;
   wire                  push;
   wire hit_rec_t        hit;
   wire                  fifo_pop;
   wire                  fifo_empty;
   wire hit_rec_t        fifo_data;

   blast_sequencer sequencer_i (
      .clk          (clk),
      .reset        (reset),
      .app_ready    (app_ready),
      .app_code     (app_code),
      .dat_r        (dat_r),
      .ack          (ack),
      .q_busy       (q_busy),
      .s_busy       (s_busy),
      .scan_idle    (scan_idle),
      .fifo_empty   (fifo_empty),
      .fifo_data    (fifo_data),
      .busy         (busy),
      .cyc          (cyc),
      .stb          (stb),
      .we           (we),
      .adr          (adr),
      .dat_w        (dat_w),
      .q_word_valid (q_word_valid),
      .q_start      (q_start),
      .s_word_valid (s_word_valid),
      .s_start      (s_start),
      .s_word       (s_word),
      .block        (block),
      .fifo_pop     (fifo_pop)
   );

   // query words come straight off the bus
   char_serializer #(.num_words(query_words)) query_ser (
      .clk        (clk),
      .reset      (reset),
      .word       (dat_r),
      .word_valid (q_word_valid),
      .start      (q_start),
      .char_out   (q_char),
      .char_valid (q_valid),
      .busy       (q_busy)
   );

   char_serializer #(.num_words(block_words)) subject_ser (
      .clk        (clk),
      .reset      (reset),
      .word       (s_word),
      .word_valid (s_word_valid),
      .start      (s_start),
      .char_out   (s_char),
      .char_valid (s_valid),
      .busy       (s_busy)
   );

   seed_scanner scanner_i (
      .clk     (clk),
      .reset   (reset),
      .q_char  (q_char),
      .q_valid (q_valid),
      .s_char  (s_char),
      .s_valid (s_valid),
      .block   (block),
      .push    (push),
      .hit     (hit),
      .idle    (scan_idle)
   );

   hit_fifo fifo_i (
      .clk   (clk),
      .reset (reset),
      .push  (push),
      .din   (hit),
      .pop   (fifo_pop),
      .dout  (fifo_data),
      .empty (fifo_empty)
   );

endmodule

`default_nettype wire

/* tb_clock.sv */
`default_nettype none

module tb_clock #(
   parameter int period = 20
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever begin
         #(period / 2) clk = ~clk;
      end
   end

endmodule

`default_nettype wire

/* blast_tb.sv */
`default_nettype none

module blast_tb import blast_pkg::*; ();

   // two query loads and eight blocks, each well under 600 cycles
   localparam int max_cycles = 20000;
   localparam int max_blocks = 3;
   localparam int max_chars  = max_blocks * block_chars;

   wire                  clk;
   logic                 reset;
   logic                 app_ready;
   logic [7:0]           app_code;
   wire                  busy;
   wire                  cyc;
   wire                  stb;
   wire                  we;
   wire  [addr_bits-1:0] adr;
   wire  [word_bits-1:0] dat_w;
   logic [word_bits-1:0] dat_r = '0;
   logic                 ack = 1'b0;

   logic [word_bits-1:0] mem [logic [addr_bits-1:0]];
   logic [31:0]          lcg_state;
   logic [char_bits-1:0] query [query_chars];
   logic [char_bits-1:0] subject [max_chars];
   mem_word_u            exp_q [$];
   logic [addr_bits-1:0] exp_adr_q [$];
   logic [addr_bits-1:0] wr_adr_q [$];
   logic [word_bits-1:0] wr_dat_q [$];
   int                   cycles = 0;
   int                   bus_cycles = 0;
   int                   busy_cycles = 0;
   int                   wait_left = 0;
   logic                 waiting = 1'b0;

   tb_clock #(.period(20)) clock_i (.clk(clk));

   blast_top blast_top_i (
      .clk       (clk),
      .reset     (reset),
      .app_ready (app_ready),
      .app_code  (app_code),
      .busy      (busy),
      .cyc       (cyc),
      .stb       (stb),
      .we        (we),
      .adr       (adr),
      .dat_w     (dat_w),
      .dat_r     (dat_r),
      .ack       (ack)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic int rand_below(int n);
      logic [31:0] v;
      v = lcg_next();
      return 32'(v[30:16]) % n;
   endfunction

   function automatic logic [word_bits-1:0] read_word(logic [addr_bits-1:0] a);
      if (mem.exists(a)) begin
         return mem[a];
      end
      // unwritten words repeat their own address
      return {4{2'b10, a}};
   endfunction

   task automatic value_error(string msg);
      $display("FAIL at time %0t: %s", $time, msg);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first mismatch");
   endtask

   task automatic run_error(string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "stopped on a run error");
   endtask

   // every query window is compared with every window of each full block
   function automatic void expected_hits(
      input  logic [char_bits-1:0] q [query_chars],
      input  logic [char_bits-1:0] s [max_chars],
      input  int                   nblocks,
      input  logic [31:0]          id,
      output hit_rec_t             recs [$],
      output mem_word_u            header
   );
      hit_rec_t rec;
      int       cnt;
      int       first;
      logic     match;
      recs = {};
      for (int b = 0; b < nblocks; b++) begin
         for (int p = 0; p <= block_chars - seed_len; p++) begin
            cnt   = 0;
            first = 0;
            for (int qp = 0; qp <= query_chars - seed_len; qp++) begin
               match = 1'b1;
               for (int k = 0; k < seed_len; k++) begin
                  if (q[qp+k] != s[b*block_chars+p+k]) begin
                     match = 1'b0;
                  end
               end
               if (match) begin
                  if (cnt == 0) begin
                     first = qp;
                  end
                  cnt++;
               end
            end
            if (cnt > 0) begin
               rec.q_pos = field_bits'(first);
               rec.s_pos = field_bits'(p);
               rec.block = field_bits'(b);
               rec.count = field_bits'(cnt);
               recs.push_back(rec);
            end
         end
      end
      header.header.subject_id = id;
      header.header.length     = 32'(recs.size() * (word_bits / 8));
   endfunction

   task automatic check_hit(logic [addr_bits-1:0] got_adr, logic [addr_bits-1:0] exp_adr,
                            hit_rec_t got, hit_rec_t exp);
      if (got_adr != exp_adr || got != exp) begin
         value_error($sformatf("hit record at %0d is %h, expected %h at %0d",
                               got_adr, got, exp, exp_adr));
      end
   endtask

   task automatic check_header(logic [addr_bits-1:0] got_adr, mem_word_u got, mem_word_u exp);
      if (got_adr != hit_base) begin
         value_error($sformatf("header written to %0d instead of %0d", got_adr, hit_base));
      end
      if (got.header.subject_id != exp.header.subject_id) begin
         value_error($sformatf("header subject_id %h, expected %h",
                               got.header.subject_id, exp.header.subject_id));
      end
      if (got.header.length != exp.header.length) begin
         value_error($sformatf("header hit bytes %0d, expected %0d",
                               got.header.length, exp.header.length));
      end
   endtask

   task automatic make_query();
      for (int i = 0; i < query_chars; i++) begin
         query[i] = char_bits'(rand_below(7));
      end
   endtask

   task automatic load_query();
      logic [query_chars*char_bits-1:0] bits;
      for (int i = 0; i < query_chars; i++) begin
         bits[i*char_bits +: char_bits] = query[i];
      end
      for (int w = 0; w < query_words; w++) begin
         mem[query_base + addr_bits'(w)] = bits[w*word_bits +: word_bits];
      end
   endtask

   // random characters with copies of query windows planted in each block
   task automatic make_subject(int nblocks, int plants);
      int p;
      int qp;
      for (int i = 0; i < max_chars; i++) begin
         subject[i] = char_bits'(rand_below(8));
      end
      for (int b = 0; b < nblocks; b++) begin
         for (int n = 0; n < plants; n++) begin
            p  = b * block_chars + rand_below(block_chars - seed_len + 1);
            qp = rand_below(query_chars - seed_len + 1);
            for (int k = 0; k < seed_len; k++) begin
               subject[p+k] = query[qp+k];
            end
         end
      end
   endtask

   // query never holds 7, and every window here does
   task automatic make_no_hit_subject();
      for (int i = 0; i < max_chars; i++) begin
         subject[i] = (i % 3 == 0) ? 3'd7 : char_bits'(rand_below(8));
      end
   endtask

   task automatic load_subject(logic [31:0] id, int length);
      logic [max_chars*char_bits-1:0] bits;
      mem_word_u                      hdr;
      for (int i = 0; i < max_chars; i++) begin
         bits[i*char_bits +: char_bits] = subject[i];
      end
      hdr.header.subject_id = id;
      hdr.header.length     = 32'(length);
      mem[subject_base] = hdr.raw;
      for (int w = 0; w < max_blocks * block_words; w++) begin
         mem[subject_base + addr_bits'(1 + w)] = bits[w*word_bits +: word_bits];
      end
   endtask

   task automatic run_command(logic [7:0] code);
      @(negedge clk);
      app_ready = 1'b1;
      app_code  = code;
      @(negedge clk);
      app_ready = 1'b0;
      if (!busy) begin
         run_error($sformatf("busy did not rise after command %h", code));
      end
      while (busy) begin
         @(negedge clk);
      end
   endtask

   task automatic scan_and_check(input logic [31:0] id, input int length, output int hits,
                                 output logic [word_bits-1:0] sig, output int top_block);
      hit_rec_t  recs [$];
      mem_word_u hdr;
      mem_word_u w;
      load_subject(id, length);
      expected_hits(query, subject, (length + block_chars - 1) / block_chars, id, recs, hdr);
      sig       = '0;
      top_block = 0;
      foreach (recs[i]) begin
         w.hit.rec = recs[i];
         w.hit.pad = '0;
         exp_q.push_back(w);
         exp_adr_q.push_back(hit_base + addr_bits'(1 + i));
         sig       = sig + w.raw;
         top_block = int'(recs[i].block);
      end
      // header goes last
      exp_q.push_back(hdr);
      exp_adr_q.push_back(hit_base);
      hits = recs.size();
      run_command(cmd_scan_subject);
      if (exp_q.size() != 0) begin
         run_error($sformatf("subject %h ended with %0d expected writes missing",
                             id, exp_q.size()));
      end
   endtask

   // wishbone slave with 0 to 3 wait cycles per transfer
   always @(negedge clk) begin
      if (reset) begin
         ack <= 1'b0;
         waiting = 1'b0;
      end else if (ack) begin
         ack <= 1'b0;
      end else if (cyc && stb) begin
         if (!waiting) begin
            wait_left = rand_below(4);
            waiting   = 1'b1;
         end
         if (wait_left == 0) begin
            waiting = 1'b0;
            ack <= 1'b1;
            if (we) begin
               mem[adr] = dat_w;
               wr_adr_q.push_back(adr);
               wr_dat_q.push_back(dat_w);
            end else begin
               dat_r <= read_word(adr);
            end
         end else begin
            wait_left--;
         end
      end
   end

   always @(posedge clk) begin : compare_writes
      logic [addr_bits-1:0] got_adr;
      logic [addr_bits-1:0] exp_adr;
      mem_word_u            got;
      mem_word_u            exp;
      while (wr_adr_q.size() > 0) begin
         got_adr = wr_adr_q.pop_front();
         got.raw = wr_dat_q.pop_front();
         if (exp_q.size() == 0) begin
            run_error($sformatf("write to %0d when none was expected", got_adr));
         end
         exp     = exp_q.pop_front();
         exp_adr = exp_adr_q.pop_front();
         if (exp_adr == hit_base) begin
            check_header(got_adr, got, exp);
         end else begin
            check_hit(got_adr, exp_adr, got.hit.rec, exp.hit.rec);
            if (got.hit.pad != '0) begin
               value_error($sformatf("hit record at %0d has pad bits %h", got_adr, got.hit.pad));
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cyc) begin
         bus_cycles <= bus_cycles + 1;
      end
      if (busy) begin
         busy_cycles <= busy_cycles + 1;
      end
      if (cycles >= max_cycles) begin
         run_error($sformatf("run did not finish within %0d cycles", max_cycles));
      end
   end

   initial begin
      int                   hits [4];
      int                   top [4];
      logic [word_bits-1:0] sig [4];
      logic [char_bits-1:0] kept [max_chars];
      int                   bus_before;
      int                   busy_before;
      lcg_state = 32'd23;
      reset     = 1'b1;
      app_ready = 1'b0;
      app_code  = 8'h00;
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      make_query();
      load_query();
      run_command(cmd_load_query);

      make_subject(1, 3);
      scan_and_check(32'h0000_0101, 64, hits[0], sig[0], top[0]);
      if (hits[0] == 0) begin
         run_error("planted seeds gave no expected hits in the one block subject");
      end

      // last block runs past the length of 150
      make_subject(3, 2);
      kept = subject;
      scan_and_check(32'h0000_0202, 150, hits[1], sig[1], top[1]);
      if (top[1] != 2) begin
         run_error("three block subject has no expected hit in block 2");
      end

      make_no_hit_subject();
      scan_and_check(32'h0000_0303, 64, hits[2], sig[2], top[2]);
      if (hits[2] != 0) begin
         run_error("subject meant to miss shares a window with the query");
      end

      make_query();
      load_query();
      run_command(cmd_load_query);
      subject = kept;
      scan_and_check(32'h0000_0202, 150, hits[3], sig[3], top[3]);
      if (hits[3] == hits[1] && sig[3] == sig[1]) begin
         run_error("new query predicts the same records as the old one");
      end

      bus_before  = bus_cycles;
      busy_before = busy_cycles;
      @(negedge clk);
      app_ready = 1'b1;
      app_code  = 8'h5C;
      @(negedge clk);
      app_ready = 1'b0;
      repeat (20) @(negedge clk);
      if (bus_cycles != bus_before || busy_cycles != busy_before) begin
         run_error("unknown command code started bus or busy activity");
      end
      if (busy) begin
         run_error("busy still high after all commands");
      end
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
blast_pkg.sv
seed_scanner.sv
hit_fifo.sv
char_serializer.sv
blast_sequencer.sv
blast_top.sv
tb_clock.sv
blast_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log holds the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module blast_tb -f build.f -o blast_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/blast_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation did not pass, see sim.log"
exit 1
